// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // basic widths of the fetch path
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;

    // path tag, bumped on every redirect
    typedef logic [1:0] epoch_t;

    localparam addr_t RESET_PC_DEFAULT = 64'h0000_0000_8000_0000;

    // read request toward the instruction memory
    typedef struct packed {
        addr_t  addr;
        epoch_t epoch;
    } mem_req_t;

    // read response, address and epoch travel with the data
    typedef struct packed {
        addr_t       addr;
        epoch_t      epoch;
        logic [63:0] data;
    } mem_rsp_t;

    // packet handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // control flow change reported by the memory stage
    typedef struct packed {
        logic  jal;
        logic  jalr;
        logic  branch;
        // compare result of the branch, taken when set
        logic  alu_zero;
        addr_t pc;
        addr_t imm;
        addr_t r1data;
        logic  trap;
        addr_t mtvec;
    } redirect_t;

endpackage

// ==== src/pc_gen.sv ====
`timescale 1ns/1ns

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  pc_advance_i,
    output fetch_pkg::addr_t      fetch_pc_o,
    output fetch_pkg::epoch_t     epoch_o,
    output logic                  redirect_valid_o
);

    fetch_pkg::addr_t  pc_q;
    fetch_pkg::epoch_t epoch_q;
    fetch_pkg::addr_t  jalr_sum;
    fetch_pkg::addr_t  target;
    logic              take_rel;
    logic              take_jalr;
    logic              take_trap;

    // pc relative jump: jal or a taken branch
    assign take_rel  = redirect_i.jal | (redirect_i.branch & redirect_i.alu_zero);
    assign take_jalr = redirect_i.jalr;
    assign take_trap = redirect_i.trap;

    assign jalr_sum = redirect_i.r1data + redirect_i.imm;

    assign redirect_valid_o = take_rel | take_jalr | take_trap;

    // priority: relative jump, then jalr, then trap
    always_comb begin
        if (take_rel) begin
            target = redirect_i.pc + redirect_i.imm;
        end else if (take_jalr) begin
            // jalr clears the low bit of the sum
            target = {jalr_sum[63:1], 1'b0};
        end else begin
            target = redirect_i.mtvec;
        end
    end

    // redirect wins over a sequential advance in the same cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_o) begin
            pc_q <= target;
        end else if (pc_advance_i) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    // new path, new tag
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            epoch_q <= '0;
        end else if (redirect_valid_o) begin
            epoch_q <= epoch_q + 2'd1;
        end
    end

    assign fetch_pc_o = pc_q;
    assign epoch_o    = epoch_q;

    // targets from the memory stage are expected word aligned
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fetch_pc_o[1:0] == 2'b00
    ) else $error("fetch pc %h is not word aligned", fetch_pc_o);

endmodule

// ==== src/inst_mem.sv ====
`timescale 1ns/1ns

module inst_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          req_valid_i,
    input  fetch_pkg::mem_req_t           req_i,
    input  logic                          we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  waddr_i,
    input  logic [63:0]                   wdata_i,
    output logic                          rsp_valid_o,
    output fetch_pkg::mem_rsp_t           rsp_o
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [63:0]         mem [MEM_WORDS];
    logic                s1_valid;
    fetch_pkg::mem_req_t s1_req;
    logic [AW-1:0]       s1_index;

    // load port used by the testbench
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // word index from address bits 3 upward, wraps at the array size
    assign s1_index = s1_req.addr[3 +: AW];

    // stage valids, a new request may enter every cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            s1_valid    <= req_valid_i;
            rsp_valid_o <= s1_valid;
        end
    end

    // stage 1 latches the request
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            s1_req <= req_i;
        end
    end

    // stage 2 reads the array, address and epoch ride along
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp_o.addr  <= s1_req.addr;
            rsp_o.epoch <= s1_req.epoch;
            rsp_o.data  <= mem[s1_index];
        end
    end

endmodule

// ==== src/credit_fifo.sv ====
`timescale 1ns/1ns

module credit_fifo #(
    parameter type payload_t   = logic [31:0],
    parameter int  DEPTH       = 4,
    parameter int  OUT_CREDITS = 2
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     flush_i,
    input  logic     credit_i,
    output logic     credit_o,
    output logic     pop_valid_o,
    output payload_t pop_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int OUT_W = $clog2(OUT_CREDITS + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] pend_cnt;
    logic [CNT_W-1:0] discard;
    logic [OUT_W-1:0] out_cnt;
    logic             pop;
    logic             pend_take;

    // pop needs an entry and a downstream credit, never during flush
    assign pop = !flush_i && (count != '0) && (out_cnt != '0);

    // entries lost on flush, including one arriving this cycle
    assign discard = count + CNT_W'(push_i);

    // pending credits go out only in cycles without a pop credit
    assign pend_take = !pop && (pend_cnt != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // registered output stage
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pop_valid_o <= 1'b0;
        end else begin
            pop_valid_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pop_data_o <= mem[rd_ptr];
        end
    end

    // one credit per freed entry, flushed entries drain one per cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_o <= 1'b0;
            pend_cnt <= '0;
        end else begin
            credit_o <= pop | pend_take;
            pend_cnt <= pend_cnt + (flush_i ? discard : '0) - CNT_W'(pend_take);
        end
    end

    // downstream credit counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_cnt <= OUT_W'(OUT_CREDITS);
        end else begin
            out_cnt <= out_cnt - OUT_W'(pop) + OUT_W'(credit_i);
        end
    end

    // sender must hold a credit for every push
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push_i |-> (count < CNT_W'(DEPTH))
    ) else $error("push into a full buffer");

    // receiver returns no more credits than it granted
    a_out_bound : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_cnt <= OUT_W'(OUT_CREDITS)
    ) else $error("downstream credit count above %0d", OUT_CREDITS);

endmodule

// ==== src/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter int RSP_DEPTH   = 4,
    parameter int FETCH_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  fetch_pkg::addr_t       fetch_pc_i,
    input  fetch_pkg::epoch_t      epoch_i,
    input  logic                   redirect_valid_i,
    input  logic                   rsp_valid_i,
    input  fetch_pkg::mem_rsp_t    rsp_i,
    input  logic                   rsp_credit_i,
    input  logic                   pkt_credit_i,
    output logic                   req_valid_o,
    output fetch_pkg::mem_req_t    req_o,
    output logic                   pc_advance_o,
    output logic                   pkt_push_o,
    output fetch_pkg::fetch_pkt_t  pkt_o
);

    localparam int MAX_DEPTH = (RSP_DEPTH > FETCH_DEPTH) ? RSP_DEPTH : FETCH_DEPTH;
    localparam int CNT_W     = $clog2(MAX_DEPTH + 1);

    logic [CNT_W-1:0] rsp_cred;
    logic [CNT_W-1:0] pkt_cred;
    logic [CNT_W-1:0] inflight;
    logic             issue;
    logic             accept;

    // a read needs a response slot, and every read still in flight
    // must find room in the fetch buffer
    assign issue = !redirect_valid_i && (rsp_cred != '0) && (inflight < pkt_cred);

    // old epoch or a redirect this cycle means the path is gone
    assign accept = rsp_valid_i && !redirect_valid_i && (rsp_i.epoch == epoch_i);

    assign pc_advance_o = issue;

    // credit counters for both buffers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_cred <= CNT_W'(RSP_DEPTH);
            pkt_cred <= CNT_W'(FETCH_DEPTH);
        end else begin
            rsp_cred <= rsp_cred - CNT_W'(issue) + CNT_W'(rsp_credit_i);
            pkt_cred <= pkt_cred - CNT_W'(accept) + CNT_W'(pkt_credit_i);
        end
    end

    // reads issued and not yet back from the response buffer
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inflight <= '0;
        end else begin
            inflight <= inflight + CNT_W'(issue) - CNT_W'(rsp_valid_i);
        end
    end

    // request register toward memory
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_o.addr  <= fetch_pc_i;
            req_o.epoch <= epoch_i;
        end
    end

    // packet register toward the fetch buffer
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_push_o <= 1'b0;
        end else begin
            pkt_push_o <= accept;
        end
    end

    // bit 2 picks the upper or lower instruction of the word
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_o.pc   <= rsp_i.addr;
            pkt_o.inst <= rsp_i.addr[2] ? rsp_i.data[63:32] : rsp_i.data[31:0];
        end
    end

    // room was reserved at issue time, so a slot is always there
    a_pkt_credit : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        accept |-> (pkt_cred != '0)
    ) else $error("accepted a response without a fetch buffer credit");

endmodule

// ==== src/fetch_subsys.sv ====
`timescale 1ns/1ns

module fetch_subsys #(
    parameter fetch_pkg::addr_t RESET_PC       = fetch_pkg::RESET_PC_DEFAULT,
    parameter int               MEM_WORDS      = 1024,
    parameter int               RSP_DEPTH      = 4,
    parameter int               FETCH_DEPTH    = 4,
    parameter int               DECODE_CREDITS = 2
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  fetch_pkg::redirect_t          redirect_i,
    output logic                          fetch_valid_o,
    output fetch_pkg::fetch_pkt_t         fetch_pkt_o,
    input  logic                          credit_i,
    input  logic                          mem_we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  mem_waddr_i,
    input  logic [63:0]                   mem_wdata_i
);

    fetch_pkg::addr_t      fetch_pc;
    fetch_pkg::epoch_t     cur_epoch;
    logic                  redirect_valid;
    logic                  pc_advance;
    logic                  req_valid;
    fetch_pkg::mem_req_t   mem_req;
    logic                  rsp_valid;
    fetch_pkg::mem_rsp_t   mem_rsp;
    logic                  rsp_pop_valid;
    fetch_pkg::mem_rsp_t   rsp_pop;
    logic                  rsp_credit;
    logic                  pkt_push;
    fetch_pkg::fetch_pkt_t pkt;
    logic                  pkt_credit;

    pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_i(redirect_i), .pc_advance_i(pc_advance),
        .fetch_pc_o(fetch_pc), .epoch_o(cur_epoch), .redirect_valid_o(redirect_valid)
    );

    inst_mem #(.MEM_WORDS(MEM_WORDS)) u_inst_mem (
        .clk(clk), .rst_n_i(rst_n_i), .req_valid_i(req_valid), .req_i(mem_req),
        .we_i(mem_we_i), .waddr_i(mem_waddr_i), .wdata_i(mem_wdata_i),
        .rsp_valid_o(rsp_valid), .rsp_o(mem_rsp)
    );

    // fetch_ctrl takes every pop, so each pop hands its credit straight back
    credit_fifo #(
        .payload_t(fetch_pkg::mem_rsp_t), .DEPTH(RSP_DEPTH), .OUT_CREDITS(RSP_DEPTH)
    ) u_rsp_buffer (
        .clk(clk), .rst_n_i(rst_n_i), .push_i(rsp_valid), .push_data_i(mem_rsp),
        .flush_i(1'b0), .credit_i(rsp_pop_valid), .credit_o(rsp_credit),
        .pop_valid_o(rsp_pop_valid), .pop_data_o(rsp_pop)
    );

    fetch_ctrl #(.RSP_DEPTH(RSP_DEPTH), .FETCH_DEPTH(FETCH_DEPTH)) u_fetch_ctrl (
        .clk(clk), .rst_n_i(rst_n_i), .fetch_pc_i(fetch_pc), .epoch_i(cur_epoch),
        .redirect_valid_i(redirect_valid), .rsp_valid_i(rsp_pop_valid), .rsp_i(rsp_pop),
        .rsp_credit_i(rsp_credit), .pkt_credit_i(pkt_credit), .req_valid_o(req_valid),
        .req_o(mem_req), .pc_advance_o(pc_advance), .pkt_push_o(pkt_push), .pkt_o(pkt)
    );

    // redirect drops everything queued for decode
    credit_fifo #(
        .payload_t(fetch_pkg::fetch_pkt_t), .DEPTH(FETCH_DEPTH), .OUT_CREDITS(DECODE_CREDITS)
    ) u_fetch_buffer (
        .clk(clk), .rst_n_i(rst_n_i), .push_i(pkt_push), .push_data_i(pkt),
        .flush_i(redirect_valid), .credit_i(credit_i), .credit_o(pkt_credit),
        .pop_valid_o(fetch_valid_o), .pop_data_o(fetch_pkt_o)
    );

endmodule

// ==== testbench/fetch_ref_model.sv ====
`timescale 1ns/1ns

module fetch_ref_model #(
    parameter fetch_pkg::addr_t RESET_PC       = fetch_pkg::RESET_PC_DEFAULT,
    parameter int               MEM_WORDS      = 64,
    parameter int               DECODE_CREDITS = 2
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          mem_we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  mem_waddr_i,
    input  logic [63:0]                   mem_wdata_i,
    input  fetch_pkg::redirect_t          redirect_i,
    input  logic                          fetch_valid_i,
    input  fetch_pkg::fetch_pkt_t         fetch_pkt_i,
    input  logic                          credit_i,
    output int                            pkt_count_o,
    output int                            outstanding_o,
    output logic                          error_o
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [63:0]      mem_copy [MEM_WORDS];
    fetch_pkg::addr_t exp_pc;

    // word from pc bits 3 upward, half from pc bit 2
    function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::addr_t pc);
        logic [63:0] word;
        word = mem_copy[pc[3 +: AW]];
        return pc[2] ? word[63:32] : word[31:0];
    endfunction

    function automatic logic takes_redirect(input fetch_pkg::redirect_t r);
        return r.jal || (r.branch && r.alu_zero) || r.jalr || r.trap;
    endfunction

    // relative jump first, then jalr, then trap
    function automatic fetch_pkg::addr_t redirect_target(input fetch_pkg::redirect_t r);
        fetch_pkg::addr_t sum;
        sum = r.r1data + r.imm;
        if (r.jal || (r.branch && r.alu_zero)) begin
            return r.pc + r.imm;
        end else if (r.jalr) begin
            return sum & ~64'h1;
        end
        return r.mtvec;
    endfunction

    initial begin
        error_o = 1'b0;
    end

    // shadow copy of the program image
    always @(posedge clk) begin
        if (mem_we_i) begin
            mem_copy[mem_waddr_i] <= mem_wdata_i;
        end
    end

    // outputs and redirect inputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            exp_pc        = RESET_PC;
            pkt_count_o   = 0;
            outstanding_o = 0;
        end else begin
            if (fetch_valid_i) begin
                assert (fetch_pkt_i.pc == exp_pc) else begin
                    $display("[FAIL] %0t ns: packet pc %h, expected %h",
                             $time, fetch_pkt_i.pc, exp_pc);
                    error_o = 1'b1;
                end
                assert (fetch_pkt_i.inst == expected_inst(exp_pc)) else begin
                    $display("[FAIL] %0t ns: instruction %h at pc %h, expected %h",
                             $time, fetch_pkt_i.inst, exp_pc, expected_inst(exp_pc));
                    error_o = 1'b1;
                end
                exp_pc        = exp_pc + 64'd4;
                pkt_count_o   = pkt_count_o + 1;
                outstanding_o = outstanding_o + 1;
                assert (outstanding_o <= DECODE_CREDITS) else begin
                    $display("[FAIL] %0t ns: %0d packets outstanding, decode granted %0d",
                             $time, outstanding_o, DECODE_CREDITS);
                    error_o = 1'b1;
                end
            end
            if (credit_i) begin
                outstanding_o = outstanding_o - 1;
            end
            // a packet shown in the redirect cycle still belongs to the old path
            if (takes_redirect(redirect_i)) begin
                exp_pc = redirect_target(redirect_i);
            end
        end
    end

endmodule

// ==== testbench/tb_fetch_subsys.sv ====
`timescale 1ns/1ns

module tb_fetch_subsys;

    localparam fetch_pkg::addr_t RESET_PC       = fetch_pkg::RESET_PC_DEFAULT;
    localparam int               MEM_WORDS      = 64;
    localparam int               AW             = $clog2(MEM_WORDS);
    localparam int               RSP_DEPTH      = 4;
    localparam int               FETCH_DEPTH    = 4;
    localparam int               DECODE_CREDITS = 2;
    localparam int               TIMEOUT        = 5000;

    logic                  clk;
    logic                  rst_n_i;
    fetch_pkg::redirect_t  redirect;
    logic                  fetch_valid;
    fetch_pkg::fetch_pkt_t fetch_pkt;
    logic                  credit;
    logic                  mem_we;
    logic [AW-1:0]         mem_waddr;
    logic [63:0]           mem_wdata;
    int                    seed;
    int                    pkt_count;
    int                    outstanding;
    int                    burst_left;
    int                    gap_left;
    int                    snapshot;
    logic                  model_error;
    logic                  credits_on;
    logic                  redirects_on;

    fetch_subsys #(
        .RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS), .RSP_DEPTH(RSP_DEPTH),
        .FETCH_DEPTH(FETCH_DEPTH), .DECODE_CREDITS(DECODE_CREDITS)
    ) u_dut (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_i(redirect), .fetch_valid_o(fetch_valid),
        .fetch_pkt_o(fetch_pkt), .credit_i(credit), .mem_we_i(mem_we),
        .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata)
    );

    fetch_ref_model #(
        .RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS), .DECODE_CREDITS(DECODE_CREDITS)
    ) u_model (
        .clk(clk), .rst_n_i(rst_n_i), .mem_we_i(mem_we), .mem_waddr_i(mem_waddr),
        .mem_wdata_i(mem_wdata), .redirect_i(redirect), .fetch_valid_i(fetch_valid),
        .fetch_pkt_i(fetch_pkt), .credit_i(credit), .pkt_count_o(pkt_count),
        .outstanding_o(outstanding), .error_o(model_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge model_error) begin
        abort_run();
    end

    task automatic make_redirect(output fetch_pkg::redirect_t r);
        int          kind;
        logic [31:0] imm_raw;
        logic [4:0]  flags;
        r        = '0;
        kind     = $unsigned($random(seed)) % 6;
        imm_raw  = $random(seed);
        flags    = 5'($random(seed));
        r.pc     = {$random(seed), $random(seed)} & ~64'h3;
        // sign extended 20 bit offset
        r.imm    = {{44{imm_raw[19]}}, imm_raw[19:2], 2'b00};
        // jalr base is odd now and then
        r.r1data = ({$random(seed), $random(seed)} & ~64'h3) | 64'(imm_raw[31]);
        r.mtvec  = {$random(seed), $random(seed)} & ~64'h3;
        case (kind)
            0: r.jal = 1'b1;
            1: begin
                r.branch   = 1'b1;
                r.alu_zero = 1'b1;
            end
            // branch not taken
            2: r.branch = 1'b1;
            3: r.jalr = 1'b1;
            4: r.trap = 1'b1;
            default: {r.jal, r.jalr, r.branch, r.alu_zero, r.trap} = flags;
        endcase
    endtask

    // one clock of stimulus with bursts of one or two redirects and gaps of 8 or more
    task automatic drive_cycle();
        fetch_pkg::redirect_t r;
        @(posedge clk);
        #1;
        credit = credits_on && (outstanding > 0) && ($random(seed) % 4 != 0);
        r = '0;
        if (redirects_on) begin
            if (burst_left > 0) begin
                make_redirect(r);
                burst_left = burst_left - 1;
            end else if (gap_left > 0) begin
                gap_left = gap_left - 1;
            end else begin
                make_redirect(r);
                burst_left = $random(seed) & 1;
                gap_left   = 8 + ($random(seed) & 15);
            end
        end
        redirect = r;
    endtask

    task automatic wait_packets(input int count);
        int target;
        int cycles;
        target = pkt_count + count;
        cycles = 0;
        while (pkt_count < target && cycles < TIMEOUT) begin
            drive_cycle();
            cycles = cycles + 1;
        end
        if (pkt_count < target) begin
            $display("timeout: decode output stalled after %0d packets", pkt_count);
            abort_run();
        end
    endtask

    initial begin
        seed         = 92582;
        rst_n_i      = 1'b0;
        redirect     = '0;
        credit       = 1'b0;
        mem_we       = 1'b0;
        mem_waddr    = '0;
        mem_wdata    = '0;
        credits_on   = 1'b0;
        redirects_on = 1'b0;
        burst_left   = 0;
        gap_left     = 0;
        // program image goes in while the core is held in reset
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            #1;
            mem_we    = 1'b1;
            mem_waddr = AW'(i);
            mem_wdata = {$random(seed), $random(seed)};
        end
        @(posedge clk);
        #1;
        mem_we = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // straight line fetch from the reset pc
        credits_on = 1'b1;
        wait_packets(40);

        // random redirects of every kind
        redirects_on = 1'b1;
        wait_packets(200);

        // decode stops granting slots
        redirects_on = 1'b0;
        credits_on   = 1'b0;
        repeat (30) drive_cycle();
        snapshot = pkt_count;
        repeat (20) drive_cycle();
        assert (pkt_count == snapshot && outstanding == DECODE_CREDITS) else begin
            $display("[FAIL] %0t ns: output did not stop without credits, %0d outstanding",
                     $time, outstanding);
            abort_run();
        end

        // stream picks up where it stopped once credits resume
        credits_on = 1'b1;
        wait_packets(20);

        // redirects again on top of the resumed stream
        redirects_on = 1'b1;
        wait_packets(100);
        redirects_on = 1'b0;
        wait_packets(20);

        if (model_error) begin
            abort_run();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== fetch_subsys.f ====
src/fetch_pkg.sv
src/pc_gen.sv
src/inst_mem.sv
src/credit_fifo.sv
src/fetch_ctrl.sv
src/fetch_subsys.sv
testbench/fetch_ref_model.sv
testbench/tb_fetch_subsys.sv
